// File: common/pcs_pkg.sv
package pcs_pkg;

	// block geometry
	localparam int BLOCK_W = 66; // sync header plus 64-bit payload
	localparam int DATA_W  = 64;
	localparam int KEEP_W  = DATA_W/8; // one enable per data byte
	localparam int CHAR_W  = 7; // control character width
	localparam int CHAR_N  = 8; // control characters in an all-control block

	// sync headers, value as seen on block[1:0]
	localparam logic [1:0] SH_DATA = 2'b01;
	localparam logic [1:0] SH_CTRL = 2'b10;

	// block type field, first payload byte of a control block
	localparam logic [7:0] BT_IDLE  = 8'h1E; // all control characters
	localparam logic [7:0] BT_START = 8'h78; // start in lane 0
	localparam logic [7:0] BT_TERM0 = 8'h87;
	localparam logic [7:0] BT_TERM1 = 8'h99;
	localparam logic [7:0] BT_TERM2 = 8'hAA;
	localparam logic [7:0] BT_TERM3 = 8'hB4;
	localparam logic [7:0] BT_TERM4 = 8'hCC;
	localparam logic [7:0] BT_TERM5 = 8'hD2;
	localparam logic [7:0] BT_TERM6 = 8'hE1;
	localparam logic [7:0] BT_TERM7 = 8'hFF;

	// 7-bit control characters
	localparam logic [CHAR_W-1:0] CH_IDLE = 7'h00;
	localparam logic [CHAR_W-1:0] CH_ERR  = 7'h1E;

	// block lock thresholds, consecutive headers
	localparam int LOCK_GOOD_N = 32;
	localparam int LOCK_BAD_N  = 8;

	// terminate type for n data bytes ahead of the terminate
	function automatic logic [7:0] bt_term(input logic [3:0] n);
		case (n)
			4'd0: bt_term = BT_TERM0;
			4'd1: bt_term = BT_TERM1;
			4'd2: bt_term = BT_TERM2;
			4'd3: bt_term = BT_TERM3;
			4'd4: bt_term = BT_TERM4;
			4'd5: bt_term = BT_TERM5;
			4'd6: bt_term = BT_TERM6;
			default: bt_term = BT_TERM7;
		endcase
	endfunction

endpackage

// File: phy_rst/phy_rst_seq.sv
`timescale 1ns/1ps

module phy_rst_seq #(
	parameter int RST_HOLD_CYC = 16
)(
	input  logic clk_50m,
	input  logic rst_n_i,

	input  logic tx_cal_busy_i,
	input  logic rx_cal_busy_i,
	input  logic rx_is_lockedtodata_i,

	output logic tx_analogreset_o,
	output logic tx_digitalreset_o,
	output logic rx_analogreset_o,
	output logic rx_digitalreset_o,
	output logic pcs_rst_n_o
);

localparam int CNT_W = $clog2(RST_HOLD_CYC+1);

typedef enum logic [1:0] {
	ST_CAL_WAIT, // analog resets held until calibration ends
	ST_TX_HOLD,
	ST_TX_READY
} state_t;

state_t           state_q;
logic [CNT_W-1:0] tx_cnt_q;
logic [CNT_W-1:0] rx_cnt_q;
logic             rx_dig_rst_q;
logic             both_ready;
logic             rdy_sync_q;

// both analog resets leave together
assign tx_analogreset_o  = (state_q == ST_CAL_WAIT);
assign rx_analogreset_o  = (state_q == ST_CAL_WAIT);
assign tx_digitalreset_o = (state_q != ST_TX_READY); // tx_ready is its inverse
assign rx_digitalreset_o = rx_dig_rst_q;

always_ff @(posedge clk_50m or negedge rst_n_i) begin
	if (!rst_n_i) begin
		state_q  <= ST_CAL_WAIT;
		tx_cnt_q <= '0;
	end else begin
		case (state_q)
			ST_CAL_WAIT: begin
				if (!tx_cal_busy_i && !rx_cal_busy_i) begin
					state_q <= ST_TX_HOLD;
				end
			end
			ST_TX_HOLD: begin
				tx_cnt_q <= tx_cnt_q + 1'b1;
				if (tx_cnt_q == CNT_W'(RST_HOLD_CYC-1)) begin
					state_q <= ST_TX_READY;
				end
			end
			default: begin
				tx_cnt_q <= '0; // tx side running
			end
		endcase
	end
end

// rx digital reset needs an unbroken run of lockedtodata
always_ff @(posedge clk_50m or negedge rst_n_i) begin
	if (!rst_n_i) begin
		rx_dig_rst_q <= 1'b1;
		rx_cnt_q     <= '0;
	end else if (state_q == ST_CAL_WAIT || !rx_is_lockedtodata_i) begin
		rx_dig_rst_q <= 1'b1; // lock lost, start the hold over
		rx_cnt_q     <= '0;
	end else if (rx_dig_rst_q) begin
		if (rx_cnt_q == CNT_W'(RST_HOLD_CYC-1)) begin
			rx_dig_rst_q <= 1'b0;
		end else begin
			rx_cnt_q <= rx_cnt_q + 1'b1;
		end
	end
end

assign both_ready = !tx_digitalreset_o && !rx_dig_rst_q;

// 2-flop stage for the pcs reset
always_ff @(posedge clk_50m or negedge rst_n_i) begin
	if (!rst_n_i) begin
		rdy_sync_q  <= 1'b0;
		pcs_rst_n_o <= 1'b0;
	end else begin
		rdy_sync_q  <= both_ready;
		pcs_rst_n_o <= rdy_sync_q;
	end
end

a_tx_dig_hold: assert property (@(posedge clk_50m) disable iff (!rst_n_i)
	!tx_digitalreset_o |-> $past(!tx_analogreset_o, RST_HOLD_CYC));

a_rx_dig_hold: assert property (@(posedge clk_50m) disable iff (!rst_n_i)
	!rx_digitalreset_o |-> $past(!rx_analogreset_o, RST_HOLD_CYC));

// pcs reset released only behind both digital resets
a_pcs_rst: assert property (@(posedge clk_50m) disable iff (!rst_n_i)
	pcs_rst_n_o |-> !tx_digitalreset_o && $past(!rx_digitalreset_o, 2));

endmodule

// File: pcs_rx/pcs_rx_dec.sv
`timescale 1ns/1ps

module pcs_rx_dec (
	input  logic                         clk_50m,
	input  logic                         rst_n_i,
	input  logic [pcs_pkg::BLOCK_W-1:0]  block_i,
	output logic                         signal_ok_o,
	output logic                         valid_o,
	output logic                         ctrl_o,
	output logic                         idle_o,
	output logic                         start_o,
	output logic                         term_o,
	output logic                         err_o,
	output logic [pcs_pkg::DATA_W-1:0]   data_o,
	output logic [pcs_pkg::KEEP_W-1:0]   keep_o
);

localparam int GOOD_W = $clog2(pcs_pkg::LOCK_GOOD_N);
localparam int BAD_W  = $clog2(pcs_pkg::LOCK_BAD_N);

logic [1:0]                  sh;
logic [pcs_pkg::DATA_W-1:0]  payload;
logic [7:0]                  btype;
logic                        hdr_ok;
logic [GOOD_W-1:0]           good_cnt_q;
logic [BAD_W-1:0]            bad_cnt_q;
logic                        d_ctrl;
logic                        d_idle;
logic                        d_start;
logic                        d_term;
logic                        d_err;
logic [pcs_pkg::DATA_W-1:0]  d_data;
logic [pcs_pkg::KEEP_W-1:0]  d_keep;

assign sh      = block_i[1:0];
assign payload = block_i[pcs_pkg::BLOCK_W-1:2];
assign btype   = payload[7:0];
assign hdr_ok  = (sh == pcs_pkg::SH_DATA) || (sh == pcs_pkg::SH_CTRL);

// block lock: consecutive good headers to gain, consecutive bad to lose
always_ff @(posedge clk_50m or negedge rst_n_i) begin
	if (!rst_n_i) begin
		signal_ok_o <= 1'b0;
		good_cnt_q  <= '0;
		bad_cnt_q   <= '0;
	end else if (!signal_ok_o) begin
		bad_cnt_q <= '0;
		if (!hdr_ok) begin
			good_cnt_q <= '0;
		end else if (good_cnt_q == GOOD_W'(pcs_pkg::LOCK_GOOD_N-1)) begin
			signal_ok_o <= 1'b1;
			good_cnt_q  <= '0;
		end else begin
			good_cnt_q <= good_cnt_q + 1'b1;
		end
	end else begin
		good_cnt_q <= '0;
		if (hdr_ok) begin
			bad_cnt_q <= '0;
		end else if (bad_cnt_q == BAD_W'(pcs_pkg::LOCK_BAD_N-1)) begin
			signal_ok_o <= 1'b0;
			bad_cnt_q   <= '0;
		end else begin
			bad_cnt_q <= bad_cnt_q + 1'b1;
		end
	end
end

always_comb begin
	d_ctrl  = 1'b0;
	d_idle  = 1'b0;
	d_start = 1'b0;
	d_term  = 1'b0;
	d_err   = 1'b0;
	d_data  = '0;
	d_keep  = '0;
	case (sh)
		pcs_pkg::SH_DATA: begin
			d_data = payload;
			d_keep = '1;
		end
		pcs_pkg::SH_CTRL: begin
			d_ctrl = 1'b1;
			case (btype)
				pcs_pkg::BT_IDLE: d_idle = 1'b1;
				pcs_pkg::BT_START: begin
					d_start = 1'b1;
					d_data  = {payload[pcs_pkg::DATA_W-1:8], 8'h00}; // byte 0 held the type
					d_keep  = 8'hFE;
				end
				default: begin
					d_err = 1'b1; // unknown unless it matches a terminate
					for (int i = 0; i < 8; i++) begin
						if (btype == pcs_pkg::bt_term(4'(i))) begin
							d_err  = 1'b0;
							d_term = 1'b1;
							// tail after the last data byte rides along untouched
							d_data = {8'h00, payload[pcs_pkg::DATA_W-1:8]};
							d_keep = ~({pcs_pkg::KEEP_W{1'b1}} << i);
						end
					end
				end
			endcase
		end
		default: d_err = 1'b1; // header 00 or 11
	endcase
end

// strobes only while locked
always_ff @(posedge clk_50m or negedge rst_n_i) begin
	if (!rst_n_i) begin
		valid_o <= 1'b0;
		ctrl_o  <= 1'b0;
		idle_o  <= 1'b0;
		start_o <= 1'b0;
		term_o  <= 1'b0;
		err_o   <= 1'b0;
	end else begin
		valid_o <= signal_ok_o;
		ctrl_o  <= signal_ok_o & d_ctrl;
		idle_o  <= signal_ok_o & d_idle;
		start_o <= signal_ok_o & d_start;
		term_o  <= signal_ok_o & d_term;
		err_o   <= signal_ok_o & d_err;
	end
end

always_ff @(posedge clk_50m) begin
	data_o <= d_data;
	keep_o <= d_keep;
end

a_one_type: assert property (@(posedge clk_50m) disable iff (!rst_n_i)
	$onehot0({idle_o, start_o, term_o}));

endmodule

// File: pcs_tx/pcs_tx_enc.sv
`timescale 1ns/1ps

module pcs_tx_enc (
	input  logic                         clk_50m,
	input  logic                         rst_n_i,
	input  logic                         valid_i,
	input  logic                         ctrl_i,
	input  logic                         idle_i,
	input  logic                         start_i,
	input  logic                         term_i,
	input  logic                         err_i,
	input  logic [pcs_pkg::DATA_W-1:0]   data_i,
	input  logic [pcs_pkg::KEEP_W-1:0]   keep_i,
	output logic [pcs_pkg::BLOCK_W-1:0]  block_o
);

localparam logic [pcs_pkg::BLOCK_W-1:0] IDLE_BLK = {
	{pcs_pkg::CHAR_N{pcs_pkg::CH_IDLE}},
	pcs_pkg::BT_IDLE,
	pcs_pkg::SH_CTRL
};

localparam logic [pcs_pkg::BLOCK_W-1:0] ERR_BLK = {
	{pcs_pkg::CHAR_N{pcs_pkg::CH_ERR}},
	pcs_pkg::BT_IDLE,
	pcs_pkg::SH_CTRL
};

logic [3:0]                  term_n;
logic                        ctrl_bad;
logic [pcs_pkg::BLOCK_W-1:0] blk_d;

assign term_n = 4'($countones(keep_i)); // data bytes ahead of the terminate

// control block with no recognised type is sent as an error
assign ctrl_bad = ctrl_i && !(idle_i || start_i || term_i);

always_comb begin
	if (!valid_i) begin
		blk_d = IDLE_BLK; // nothing to send
	end else if (err_i || ctrl_bad) begin
		blk_d = ERR_BLK;
	end else if (start_i) begin
		blk_d = {data_i[pcs_pkg::DATA_W-1:8], pcs_pkg::BT_START, pcs_pkg::SH_CTRL};
	end else if (term_i) begin
		blk_d = {data_i[pcs_pkg::DATA_W-9:0], pcs_pkg::bt_term(term_n), pcs_pkg::SH_CTRL};
	end else if (idle_i) begin
		blk_d = IDLE_BLK;
	end else begin
		blk_d = {data_i, pcs_pkg::SH_DATA};
	end
end

always_ff @(posedge clk_50m or negedge rst_n_i) begin
	if (!rst_n_i) begin
		block_o <= IDLE_BLK; // line carries idle out of reset
	end else begin
		block_o <= blk_d;
	end
end

// keep for a terminate must be n low ones, n at most 7
a_term_keep: assert property (@(posedge clk_50m) disable iff (!rst_n_i)
	valid_i && term_i |->
		((keep_i & (keep_i + 1'b1)) == '0) && !keep_i[pcs_pkg::KEEP_W-1]);

endmodule

// File: hdl/pcs_loopback.sv
`timescale 1ns/1ps

module pcs_loopback (
	input  logic                        clk_50m,
	input  logic                        rst_n_i,
	input  logic                        rx_signal_ok_i,

	input  logic                        rx_valid_i,
	input  logic                        rx_ctrl_i,
	input  logic                        rx_idle_i,
	input  logic                        rx_start_i,
	input  logic                        rx_term_i,
	input  logic                        rx_err_i,
	input  logic [pcs_pkg::DATA_W-1:0]  rx_data_i,
	input  logic [pcs_pkg::KEEP_W-1:0]  rx_keep_i,

	output logic                        tx_valid_o,
	output logic                        tx_ctrl_o,
	output logic                        tx_idle_o,
	output logic                        tx_start_o,
	output logic                        tx_term_o,
	output logic                        tx_err_o,
	output logic [pcs_pkg::DATA_W-1:0]  tx_data_o,
	output logic [pcs_pkg::KEEP_W-1:0]  tx_keep_o
);

always_ff @(posedge clk_50m or negedge rst_n_i) begin
	if (!rst_n_i) begin
		tx_valid_o <= 1'b0;
		tx_ctrl_o  <= 1'b0;
		tx_idle_o  <= 1'b0;
		tx_start_o <= 1'b0;
		tx_term_o  <= 1'b0;
		tx_err_o   <= 1'b0;
	end else if (!rx_signal_ok_i) begin
		tx_valid_o <= 1'b1; // no lock, far end gets idle
		tx_ctrl_o  <= 1'b1;
		tx_idle_o  <= 1'b1;
		tx_start_o <= 1'b0;
		tx_term_o  <= 1'b0;
		tx_err_o   <= 1'b0;
	end else begin
		tx_valid_o <= rx_valid_i;
		tx_ctrl_o  <= rx_ctrl_i;
		tx_idle_o  <= rx_idle_i;
		tx_start_o <= rx_start_i;
		tx_term_o  <= rx_term_i;
		tx_err_o   <= rx_err_i;
	end
end

always_ff @(posedge clk_50m) begin
	tx_data_o <= rx_signal_ok_i ? rx_data_i : '0;
	tx_keep_o <= rx_signal_ok_i ? rx_keep_i : '0;
end

endmodule

// File: hdl/top_pcs.sv
`timescale 1ns/1ps

module top_pcs #(
	parameter int RST_HOLD_CYC = 16
)(
	input  logic                         clk_50m,
	input  logic                         rst_n_i,

	input  logic                         gx_tx_cal_busy_i,
	input  logic                         gx_rx_cal_busy_i,
	input  logic                         gx_rx_is_lockedtodata_i,
	input  logic [pcs_pkg::BLOCK_W-1:0]  gx_rx_par_data_i,

	output logic                         gx_tx_analogreset_o,
	output logic                         gx_tx_digitalreset_o,
	output logic                         gx_rx_analogreset_o,
	output logic                         gx_rx_digitalreset_o,
	output logic                         pcs_rx_signal_ok_o,
	output logic [pcs_pkg::BLOCK_W-1:0]  gx_tx_par_data_o
);

logic pcs_rst_n; // synchronous release, from the sequencer

logic                       rx_valid;
logic                       rx_ctrl;
logic                       rx_idle;
logic                       rx_start;
logic                       rx_term;
logic                       rx_err;
logic [pcs_pkg::DATA_W-1:0] rx_data;
logic [pcs_pkg::KEEP_W-1:0] rx_keep;

logic                       tx_valid;
logic                       tx_ctrl;
logic                       tx_idle;
logic                       tx_start;
logic                       tx_term;
logic                       tx_err;
logic [pcs_pkg::DATA_W-1:0] tx_data;
logic [pcs_pkg::KEEP_W-1:0] tx_keep;

phy_rst_seq #(
	.RST_HOLD_CYC(RST_HOLD_CYC)
) m_phy_rst (
	.clk_50m              (clk_50m),
	.rst_n_i              (rst_n_i),
	.tx_cal_busy_i        (gx_tx_cal_busy_i),
	.rx_cal_busy_i        (gx_rx_cal_busy_i),
	.rx_is_lockedtodata_i (gx_rx_is_lockedtodata_i),
	.tx_analogreset_o     (gx_tx_analogreset_o),
	.tx_digitalreset_o    (gx_tx_digitalreset_o),
	.rx_analogreset_o     (gx_rx_analogreset_o),
	.rx_digitalreset_o    (gx_rx_digitalreset_o),
	.pcs_rst_n_o          (pcs_rst_n)
);

pcs_rx_dec m_pcs_rx (
	.clk_50m     (clk_50m),
	.rst_n_i     (pcs_rst_n),
	.block_i     (gx_rx_par_data_i),
	.signal_ok_o (pcs_rx_signal_ok_o),
	.valid_o     (rx_valid),
	.ctrl_o      (rx_ctrl),
	.idle_o      (rx_idle),
	.start_o     (rx_start),
	.term_o      (rx_term),
	.err_o       (rx_err),
	.data_o      (rx_data),
	.keep_o      (rx_keep)
);

pcs_loopback m_pcs_loopback (
	.clk_50m        (clk_50m),
	.rst_n_i        (pcs_rst_n),
	.rx_signal_ok_i (pcs_rx_signal_ok_o),
	.rx_valid_i     (rx_valid),
	.rx_ctrl_i      (rx_ctrl),
	.rx_idle_i      (rx_idle),
	.rx_start_i     (rx_start),
	.rx_term_i      (rx_term),
	.rx_err_i       (rx_err),
	.rx_data_i      (rx_data),
	.rx_keep_i      (rx_keep),
	.tx_valid_o     (tx_valid),
	.tx_ctrl_o      (tx_ctrl),
	.tx_idle_o      (tx_idle),
	.tx_start_o     (tx_start),
	.tx_term_o      (tx_term),
	.tx_err_o       (tx_err),
	.tx_data_o      (tx_data),
	.tx_keep_o      (tx_keep)
);

pcs_tx_enc m_pcs_tx (
	.clk_50m (clk_50m),
	.rst_n_i (pcs_rst_n),
	.valid_i (tx_valid),
	.ctrl_i  (tx_ctrl),
	.idle_i  (tx_idle),
	.start_i (tx_start),
	.term_i  (tx_term),
	.err_i   (tx_err),
	.data_i  (tx_data),
	.keep_i  (tx_keep),
	.block_o (gx_tx_par_data_o)
);

endmodule

// File: tests/tb_top_pcs.sv
`timescale 1ns/1ps

module tb_top_pcs;

localparam int RST_HOLD_CYC = 16;
localparam int N_ROWS       = 16;
localparam int ROW_CYC      = 4; // drive, filler and two pipeline edges
localparam int WD_CYCLES    = 2*(3*RST_HOLD_CYC + 2*pcs_pkg::LOCK_GOOD_N
	+ pcs_pkg::LOCK_BAD_N + 2*N_ROWS*ROW_CYC) + 200;

typedef logic [pcs_pkg::BLOCK_W-1:0] blk_t;

localparam blk_t IDLE_BLK = {{8{pcs_pkg::CH_IDLE}}, pcs_pkg::BT_IDLE, pcs_pkg::SH_CTRL};
localparam blk_t ERR_BLK  = {{8{pcs_pkg::CH_ERR}}, pcs_pkg::BT_IDLE, pcs_pkg::SH_CTRL};

logic clk_50m;
logic rst_n_i;
logic tx_cal_busy;
logic rx_cal_busy;
logic rx_locked;
blk_t rx_par_data;
logic tx_analogreset;
logic tx_digitalreset;
logic rx_analogreset;
logic rx_digitalreset;
logic rx_signal_ok;
blk_t tx_par_data;

int   seed = 67236;
int   n_pass;
int   n_fail;
blk_t tbl_blk [N_ROWS];
blk_t tbl_exp [N_ROWS];
string tbl_tag [N_ROWS];

top_pcs #(
	.RST_HOLD_CYC(RST_HOLD_CYC)
) i_dut (
	.clk_50m                 (clk_50m),
	.rst_n_i                 (rst_n_i),
	.gx_tx_cal_busy_i        (tx_cal_busy),
	.gx_rx_cal_busy_i        (rx_cal_busy),
	.gx_rx_is_lockedtodata_i (rx_locked),
	.gx_rx_par_data_i        (rx_par_data),
	.gx_tx_analogreset_o     (tx_analogreset),
	.gx_tx_digitalreset_o    (tx_digitalreset),
	.gx_rx_analogreset_o     (rx_analogreset),
	.gx_rx_digitalreset_o    (rx_digitalreset),
	.pcs_rx_signal_ok_o      (rx_signal_ok),
	.gx_tx_par_data_o        (tx_par_data)
);

initial begin
	clk_50m = 1'b0;
	forever #10 clk_50m = ~clk_50m;
end

function automatic blk_t data_block(input logic [63:0] p);
	return {p, pcs_pkg::SH_DATA};
endfunction

function automatic blk_t ctrl_block(input logic [7:0] bt, input logic [55:0] tail);
	return {tail, bt, pcs_pkg::SH_CTRL}; // type byte sits right above the header
endfunction

task automatic next_rand(output logic [63:0] r);
	r = {$random(seed), $random(seed)};
endtask

task automatic check_level(input logic got, input logic exp, input string what);
	assert (got === exp) begin
		n_pass++;
	end else begin
		n_fail++;
		$display("mismatch at %0t ns: %s is %b, expected %b", $time, what, got, exp);
	end
endtask

task automatic check_block(input blk_t got, input blk_t exp, input string what);
	assert (got === exp) begin
		n_pass++;
	end else begin
		n_fail++;
		$display("mismatch at %0t ns: %s block %h, expected %h", $time, what, got, exp);
	end
endtask

task automatic report_test(input string name, input int mark);
	if (n_fail == mark) begin
		$display("test %s: ok", name);
	end else begin
		$display("test %s: %0d failing checks", name, n_fail - mark);
	end
endtask

task automatic set_row(input int idx, input string tag, input blk_t blk, input logic bad);
	tbl_tag[idx] = tag;
	tbl_blk[idx] = blk;
	tbl_exp[idx] = bad ? ERR_BLK : blk; // legal blocks come back unchanged
endtask

task automatic build_table();
	logic [63:0] r [N_ROWS];
	for (int i = 0; i < N_ROWS; i++) begin
		next_rand(r[i]);
	end
	set_row(0, "data", data_block(r[0]), 1'b0);
	set_row(1, "data", data_block(r[1]), 1'b0);
	set_row(2, "idle", IDLE_BLK, 1'b0);
	set_row(3, "start", ctrl_block(pcs_pkg::BT_START, r[3][63:8]), 1'b0);
	set_row(4, "term0", ctrl_block(pcs_pkg::BT_TERM0, r[4][63:8]), 1'b0);
	set_row(5, "term1", ctrl_block(pcs_pkg::BT_TERM1, r[5][63:8]), 1'b0);
	set_row(6, "term2", ctrl_block(pcs_pkg::BT_TERM2, r[6][63:8]), 1'b0);
	set_row(7, "term3", ctrl_block(pcs_pkg::BT_TERM3, r[7][63:8]), 1'b0);
	set_row(8, "term4", ctrl_block(pcs_pkg::BT_TERM4, r[8][63:8]), 1'b0);
	set_row(9, "term5", ctrl_block(pcs_pkg::BT_TERM5, r[9][63:8]), 1'b0);
	set_row(10, "term6", ctrl_block(pcs_pkg::BT_TERM6, r[10][63:8]), 1'b0);
	set_row(11, "term7", ctrl_block(pcs_pkg::BT_TERM7, r[11][63:8]), 1'b0);
	set_row(12, "data", data_block(r[12]), 1'b0);
	set_row(13, "bad type", ctrl_block(8'h55, r[13][63:8]), 1'b1); // no such block type
	set_row(14, "bad header 00", {r[14], 2'b00}, 1'b1);
	set_row(15, "bad header 11", {r[15], 2'b11}, 1'b1);
endtask

task automatic reset_order();
	int mark;
	mark = n_fail;
	repeat (7) begin
		@(negedge clk_50m);
		check_level(tx_analogreset, 1'b1, "tx_analogreset in reset");
		check_level(rx_analogreset, 1'b1, "rx_analogreset in reset");
		check_level(tx_digitalreset, 1'b1, "tx_digitalreset in reset");
		check_level(rx_digitalreset, 1'b1, "rx_digitalreset in reset");
	end
	@(posedge clk_50m);
	rst_n_i <= 1'b1;
	repeat (6) begin
		@(negedge clk_50m);
		check_level(tx_analogreset, 1'b1, "tx_analogreset while calibrating");
		check_level(rx_analogreset, 1'b1, "rx_analogreset while calibrating");
	end
	@(posedge clk_50m);
	tx_cal_busy <= 1'b0;
	repeat (4) begin
		@(negedge clk_50m);
		check_level(tx_analogreset, 1'b1, "tx_analogreset with rx still calibrating");
		check_level(rx_analogreset, 1'b1, "rx_analogreset with rx still calibrating");
	end
	@(posedge clk_50m);
	rx_cal_busy <= 1'b0;
	@(negedge clk_50m);
	check_level(tx_analogreset, 1'b1, "tx_analogreset before cal_busy is seen low");
	@(negedge clk_50m);
	check_level(tx_analogreset, 1'b0, "tx_analogreset after calibration");
	check_level(rx_analogreset, 1'b0, "rx_analogreset after calibration");
	for (int i = 1; i <= RST_HOLD_CYC; i++) begin
		@(negedge clk_50m);
		check_level(tx_digitalreset, i < RST_HOLD_CYC, "tx_digitalreset during tx hold");
		check_level(rx_digitalreset, 1'b1, "rx_digitalreset without lockedtodata");
	end
	@(posedge clk_50m);
	rx_locked <= 1'b1;
	for (int i = 0; i <= RST_HOLD_CYC; i++) begin
		@(negedge clk_50m);
		check_level(rx_digitalreset, i < RST_HOLD_CYC, "rx_digitalreset during rx hold");
	end
	report_test("reset order", mark);
endtask

task automatic acquire_lock();
	int mark;
	logic [63:0] r;
	mark = n_fail;
	repeat (4) @(posedge clk_50m); // pcs reset leaves two edges after the digital resets
	for (int i = 0; i < pcs_pkg::LOCK_GOOD_N; i++) begin
		@(posedge clk_50m);
		next_rand(r);
		rx_par_data <= data_block(r);
		@(negedge clk_50m);
		check_level(rx_signal_ok, 1'b0, "signal_ok before enough good headers");
		check_block(tx_par_data, IDLE_BLK, "tx while unlocked");
	end
	@(posedge clk_50m);
	rx_par_data <= IDLE_BLK;
	@(negedge clk_50m);
	check_level(rx_signal_ok, 1'b1, "signal_ok after the last good header");
	report_test("block lock", mark);
endtask

task automatic run_table(input string label);
	int mark;
	for (int i = 0; i < N_ROWS; i++) begin
		mark = n_fail;
		@(posedge clk_50m);
		rx_par_data <= tbl_blk[i];
		@(posedge clk_50m);
		rx_par_data <= IDLE_BLK;
		repeat (2) @(posedge clk_50m);
		@(negedge clk_50m); // three edges after the block went in
		check_block(tx_par_data, tbl_exp[i], $sformatf("%s row %0d", label, i));
		check_level(rx_signal_ok, 1'b1, "signal_ok across the row");
		report_test($sformatf("%s row %0d %s", label, i, tbl_tag[i]), mark);
	end
endtask

task automatic lose_lock();
	int mark;
	logic [63:0] r;
	mark = n_fail;
	for (int i = 0; i < pcs_pkg::LOCK_BAD_N; i++) begin
		@(posedge clk_50m);
		next_rand(r);
		rx_par_data <= {r, (i % 2 == 0) ? 2'b00 : 2'b11};
		@(negedge clk_50m);
		check_level(rx_signal_ok, 1'b1, "signal_ok before enough bad headers");
	end
	@(posedge clk_50m);
	next_rand(r);
	rx_par_data <= data_block(r);
	@(negedge clk_50m);
	check_level(rx_signal_ok, 1'b0, "signal_ok after the last bad header");
	for (int j = 0; j < 12; j++) begin
		@(posedge clk_50m);
		next_rand(r);
		rx_par_data <= data_block(r);
		@(negedge clk_50m);
		check_level(rx_signal_ok, 1'b0, "signal_ok after lock loss");
		if (j >= 1) begin
			check_block(tx_par_data, IDLE_BLK, "tx after lock loss"); // last error block gone
		end
	end
	report_test("lock loss", mark);
endtask

task automatic drop_lockedtodata();
	int mark;
	mark = n_fail;
	@(posedge clk_50m);
	rx_locked   <= 1'b0;
	rx_par_data <= IDLE_BLK;
	@(negedge clk_50m);
	check_level(rx_digitalreset, 1'b0, "rx_digitalreset before the drop is seen");
	@(negedge clk_50m);
	check_level(rx_digitalreset, 1'b1, "rx_digitalreset one cycle after the drop");
	repeat (4) begin
		@(negedge clk_50m);
		check_level(rx_digitalreset, 1'b1, "rx_digitalreset while lockedtodata is low");
	end
	@(posedge clk_50m);
	rx_locked <= 1'b1;
	for (int i = 0; i <= RST_HOLD_CYC; i++) begin
		@(negedge clk_50m);
		check_level(rx_digitalreset, i < RST_HOLD_CYC, "rx_digitalreset during second hold");
	end
	// pcs reset leaves two cycles later and the good header count starts from zero
	for (int i = 1; i <= pcs_pkg::LOCK_GOOD_N + 2; i++) begin
		@(negedge clk_50m);
		check_level(rx_signal_ok, i > pcs_pkg::LOCK_GOOD_N + 1, "signal_ok during relock");
	end
	report_test("lockedtodata drop", mark);
endtask

initial begin
	rst_n_i     = 1'b0;
	tx_cal_busy = 1'b1; // calibration runs out of reset
	rx_cal_busy = 1'b1;
	rx_locked   = 1'b0;
	rx_par_data = '0; // header 00 keeps the good count at zero
	n_pass      = 0;
	n_fail      = 0;
	build_table();
	reset_order();
	acquire_lock();
	run_table("first pass");
	lose_lock();
	drop_lockedtodata();
	run_table("after relock");
	$display("checks passed %0d, failed %0d", n_pass, n_fail);
	if (n_fail == 0) begin
		$display("TB PASSED");
	end else begin
		$display("TB FAILED");
	end
	$finish;
end

// bound covers both resets, two lock acquisitions and two table passes
initial begin
	repeat (WD_CYCLES) @(posedge clk_50m);
	$display("watchdog expired after %0d cycles, the run did not finish", WD_CYCLES);
	$display("TB FAILED");
	$finish;
end

endmodule

// File: sim.f
common/pcs_pkg.sv
phy_rst/phy_rst_seq.sv
pcs_rx/pcs_rx_dec.sv
pcs_tx/pcs_tx_enc.sv
hdl/pcs_loopback.sv
hdl/top_pcs.sv
tests/tb_top_pcs.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
	-f sim.f --top-module tb_top_pcs -o tb_top_pcs
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/tb_top_pcs)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "TB PASSED"; then
	exit 0
fi
echo "pass message not found"
exit 1
